// ==== verilog/ntt_addr_pkg.sv ====
package ntt_addr_pkg;

    // --------------------
    // widths that carry a meaning
    // --------------------

    // stage index 0..6
    typedef logic [2:0] stage_t;
    // butterfly step within a stage, 0..127
    typedef logic [6:0] loop_t;
    // address inside one 128-entry half
    typedef logic [6:0] half_addr_t;
    // bank bit on top of the half address
    typedef logic [7:0] bank_addr_t;
    // twiddle rom address
    typedef logic [8:0] tw_addr_t;

    // forward is cooley-tukey, inverse is gentleman-sande
    typedef enum logic {
        XFORM_FWD = 1'b0,
        XFORM_INV = 1'b1
    } xform_kind_t;

    // control fsm
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_FWD  = 2'd1,
        ST_INV  = 2'd2
    } ctrl_state_t;

    // --------------------
    // loop limits and twiddle start points
    // --------------------
    localparam stage_t   LAST_STAGE   = 3'd6;
    localparam loop_t    LAST_LOOP    = 7'd127;
    localparam tw_addr_t TW_START_FWD = 9'd0;
    localparam tw_addr_t TW_START_INV = 9'd127;

    // pipeline latencies, matched to the butterfly unit
    localparam int WR_EVEN_DELAY = 7;
    localparam int WR_ODD_DELAY  = 8;
    localparam int STAGE_DELAY   = 8;
    localparam int TW_DELAY      = 1;
    localparam int CT_DELAY      = 1;

endpackage

// ==== verilog/ntt_loop_if.sv ====
interface ntt_loop_if import ntt_addr_pkg::*; ();

    // one cycle, the cycle before step 0
    logic        start;
    // valid with start, held for the run
    xform_kind_t kind;
    // high while fsm runs a transform
    logic        active;
    // current step position
    stage_t      stage;
    loop_t       loop;

    // loop counter side
    modport counter (output start, kind, active, stage, loop);

    // address generator side
    modport user (input start, kind, active, stage, loop);

endinterface

// ==== verilog/delay_line.sv ====
module delay_line #(
    parameter int DEPTH = 1,
    parameter int WIDTH = 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    // tap 0 is the newest sample
    logic [WIDTH-1:0] taps [DEPTH];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                taps[i] <= '0;
            end
        end else begin
            taps[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    assign dout = taps[DEPTH-1];

endmodule

// ==== verilog/ntt_loop_counter.sv ====
module ntt_loop_counter import ntt_addr_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start_fntt,
    input  logic        start_intt,
    output logic        ct,
    ntt_loop_if.counter loop_bus
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        start_q;
    xform_kind_t kind_q;
    stage_t      stage_q;
    loop_t       loop_q;
    logic        take_start;
    logic        last_step;
    logic        fwd_flag;
    logic        fwd_flag_d;

    // strobes only count while idle and nothing is pending
    assign take_start = (state == ST_IDLE) && !start_q && (start_fntt || start_intt);
    assign last_step  = (stage_q == LAST_STAGE) && (loop_q == LAST_LOOP);

    // --------------------
    // fsm
    // --------------------
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                // leave idle one cycle after the accepted strobe
                if (start_q) begin
                    if (kind_q == XFORM_FWD) begin
                        next_state = ST_FWD;
                    end else begin
                        next_state = ST_INV;
                    end
                end
            end
            ST_FWD, ST_INV: begin
                if (last_step) begin
                    next_state = ST_IDLE;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= ST_IDLE;
            start_q <= 1'b0;
            kind_q  <= XFORM_FWD;
        end else begin
            state   <= next_state;
            start_q <= take_start;
            // forward wins when both strobes arrive together
            if (take_start) begin
                if (start_fntt) begin
                    kind_q <= XFORM_FWD;
                end else begin
                    kind_q <= XFORM_INV;
                end
            end
        end
    end

    // --------------------
    // stage and loop counters
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage_q <= '0;
            loop_q  <= '0;
        end else if (state != ST_IDLE) begin
            if (loop_q == LAST_LOOP) begin
                loop_q  <= '0;
                // wrap to 0 after the last stage so idle starts clean
                stage_q <= (stage_q == LAST_STAGE) ? 3'd0 : stage_q + 3'd1;
            end else begin
                loop_q <= loop_q + 7'd1;
            end
        end else begin
            stage_q <= '0;
            loop_q  <= '0;
        end
    end

    // --------------------
    // transform kind flag
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fwd_flag <= 1'b0;
        end else if (state == ST_FWD) begin
            fwd_flag <= 1'b1;
        end else if (state == ST_INV) begin
            fwd_flag <= 1'b0;
        end
    end

    delay_line #(
        .DEPTH (CT_DELAY),
        .WIDTH (1)
    ) u_ct_delay (
        .clk   (clk),
        .reset (reset),
        .din   (fwd_flag),
        .dout  (fwd_flag_d)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ct <= 1'b0;
        end else begin
            ct <= fwd_flag_d;
        end
    end

    // step position out to the generators
    assign loop_bus.start  = start_q;
    assign loop_bus.kind   = kind_q;
    assign loop_bus.active = (state != ST_IDLE);
    assign loop_bus.stage  = stage_q;
    assign loop_bus.loop   = loop_q;

endmodule

// ==== verilog/ntt_twiddle_addr.sv ====
module ntt_twiddle_addr import ntt_addr_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    ntt_loop_if.user loop_bus,
    output tw_addr_t raddr_tw
);

    tw_addr_t tw_cnt;
    tw_addr_t tw_next;

    // true when the low nbits of idx are all ones
    function automatic logic low_ones(loop_t idx, logic [2:0] nbits);
        loop_t mask;
        mask = loop_t'((8'd1 << nbits) - 8'd1);
        return (idx & mask) == mask;
    endfunction

    // --------------------
    // stepping rules
    // --------------------
    always_comb begin
        tw_next = tw_cnt;
        if (loop_bus.loop == LAST_LOOP) begin
            // end of stage, always move on
            tw_next = tw_cnt + 9'd1;
        end else if (loop_bus.kind == XFORM_FWD) begin
            // stage 0 uses one twiddle, later stages step every 2^(7-s) steps
            if ((loop_bus.stage != 3'd0) && low_ones(loop_bus.loop, 3'd7 - loop_bus.stage)) begin
                tw_next = tw_cnt + 9'd1;
            end
        end else if (loop_bus.stage != LAST_STAGE) begin
            // inverse walks up and back, except at block ends
            if (!loop_bus.loop[0] || low_ones(loop_bus.loop, loop_bus.stage + 3'd2)) begin
                tw_next = tw_cnt + 9'd1;
            end else begin
                tw_next = tw_cnt - 9'd1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tw_cnt <= '0;
        end else if (loop_bus.start) begin
            tw_cnt <= (loop_bus.kind == XFORM_FWD) ? TW_START_FWD : TW_START_INV;
        end else if (loop_bus.active) begin
            tw_cnt <= tw_next;
        end else begin
            tw_cnt <= '0;
        end
    end

    // rom address, no output register
    delay_line #(
        .DEPTH (TW_DELAY),
        .WIDTH ($bits(tw_addr_t))
    ) u_tw_delay (
        .clk   (clk),
        .reset (reset),
        .din   (tw_cnt),
        .dout  (raddr_tw)
    );

endmodule

// ==== verilog/ntt_read_addr.sv ====
module ntt_read_addr import ntt_addr_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    ntt_loop_if.user   loop_bus,
    output bank_addr_t raddr
);

    half_addr_t half_next;
    half_addr_t half_q;
    logic       bank_q;
    logic [2:0] pos;

    // move idx[0] to bit pos, slide bits 1..pos down one
    function automatic half_addr_t insert_bit(loop_t idx, logic [2:0] ins);
        half_addr_t low_mask;
        half_addr_t upper;
        low_mask = half_addr_t'((8'd1 << ins) - 8'd1);
        upper    = (idx >> (ins + 3'd1)) << (ins + 3'd1);
        return ((idx >> 1) & low_mask) | (half_addr_t'(idx[0]) << ins) | upper;
    endfunction

    // --------------------
    // butterfly permutation
    // --------------------
    always_comb begin
        if (loop_bus.kind == XFORM_FWD) begin
            pos = 3'd6 - loop_bus.stage;
        end else begin
            pos = loop_bus.stage + 3'd1;
        end
        // last stage reads straight through
        if (loop_bus.stage == LAST_STAGE) begin
            half_next = loop_bus.loop;
        end else begin
            half_next = insert_bit(loop_bus.loop, pos);
        end
    end

    // address register with its bank bit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            half_q <= '0;
            bank_q <= 1'b0;
        end else if (loop_bus.start) begin
            half_q <= '0;
            // inverse reads the other half first
            bank_q <= (loop_bus.kind == XFORM_INV);
        end else if (loop_bus.active) begin
            half_q <= half_next;
            // address 127 is the last read of a stage
            if (half_q == '1) begin
                bank_q <= ~bank_q;
            end
        end else begin
            half_q <= '0;
            bank_q <= 1'b0;
        end
    end

    // output register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            raddr <= '0;
        end else begin
            raddr <= {bank_q, half_q};
        end
    end

endmodule

// ==== verilog/ntt_write_addr.sv ====
module ntt_write_addr import ntt_addr_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    ntt_loop_if.user   loop_bus,
    output bank_addr_t waddr0,
    output bank_addr_t waddr1,
    output logic       wen0,
    output logic       wen1,
    output logic       brsel0,
    output logic       brsel1,
    output stage_t     stage_count
);

    logic [2:0] blk_w;
    half_addr_t even_half;
    half_addr_t odd_half;
    logic       wr_bank;
    bank_addr_t even_q;
    bank_addr_t odd_q;
    logic       wen_q;
    logic       brsel_q;
    stage_t     stage_q;
    logic [$bits(bank_addr_t)+1:0] even_d;
    logic [$bits(bank_addr_t)+1:0] odd_d;
    stage_t     stage_d;

    // --------------------
    // even and odd addresses
    // --------------------
    always_comb begin
        if (loop_bus.kind == XFORM_FWD) begin
            blk_w = 3'd6 - loop_bus.stage;
        end else begin
            blk_w = loop_bus.stage + 3'd1;
        end
        if (loop_bus.stage == LAST_STAGE) begin
            even_half = loop_bus.loop;
            odd_half  = loop_bus.loop;
        end else begin
            // block base plus offset inside the block
            even_half = (loop_bus.loop >> 1) + ((loop_bus.loop >> (blk_w + 3'd1)) << blk_w);
            // odd partner sits 2^w above
            odd_half  = even_half + (half_addr_t'(1) << blk_w);
        end
        // opposite half from the read side of this stage
        wr_bank = ~(loop_bus.stage[0] ^ (loop_bus.kind == XFORM_INV));
    end

    // address register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            even_q  <= '0;
            odd_q   <= '0;
            wen_q   <= 1'b0;
            brsel_q <= 1'b0;
            stage_q <= '0;
        end else if (loop_bus.active) begin
            even_q  <= {wr_bank, even_half};
            odd_q   <= {wr_bank, odd_half};
            wen_q   <= 1'b1;
            brsel_q <= loop_bus.loop[0];
            stage_q <= loop_bus.stage;
        end else begin
            even_q  <= '0;
            odd_q   <= '0;
            wen_q   <= 1'b0;
            brsel_q <= 1'b0;
            stage_q <= '0;
        end
    end

    // --------------------
    // butterfly latency
    // --------------------
    delay_line #(
        .DEPTH (WR_EVEN_DELAY),
        .WIDTH ($bits(bank_addr_t) + 2)
    ) u_even_delay (
        .clk   (clk),
        .reset (reset),
        .din   ({even_q, wen_q, brsel_q}),
        .dout  (even_d)
    );

    // odd lane one cycle behind even
    delay_line #(
        .DEPTH (WR_ODD_DELAY),
        .WIDTH ($bits(bank_addr_t) + 2)
    ) u_odd_delay (
        .clk   (clk),
        .reset (reset),
        .din   ({odd_q, wen_q, brsel_q}),
        .dout  (odd_d)
    );

    // stage number travels with the odd lane
    delay_line #(
        .DEPTH (STAGE_DELAY),
        .WIDTH ($bits(stage_t))
    ) u_stage_delay (
        .clk   (clk),
        .reset (reset),
        .din   (stage_q),
        .dout  (stage_d)
    );

    // output register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            waddr0      <= '0;
            waddr1      <= '0;
            wen0        <= 1'b0;
            wen1        <= 1'b0;
            brsel0      <= 1'b0;
            brsel1      <= 1'b0;
            stage_count <= '0;
        end else begin
            waddr0      <= even_d[$bits(bank_addr_t)+1:2];
            wen0        <= even_d[1];
            brsel0      <= even_d[0];
            waddr1      <= odd_d[$bits(bank_addr_t)+1:2];
            wen1        <= odd_d[1];
            brsel1      <= odd_d[0];
            stage_count <= stage_d;
        end
    end

endmodule

// ==== verilog/ntt_addr_gen.sv ====
module ntt_addr_gen import ntt_addr_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       start_fntt,
    input  logic       start_intt,
    output logic       ct,
    output bank_addr_t raddr,
    output tw_addr_t   raddr_tw,
    output bank_addr_t waddr0,
    output bank_addr_t waddr1,
    output logic       wen0,
    output logic       wen1,
    output logic       brsel0,
    output logic       brsel1,
    output stage_t     stage_count
);

    // step position shared by all generators
    ntt_loop_if loop_bus ();

    // --------------------
    // control
    // --------------------
    ntt_loop_counter u_loop_counter (
        .clk        (clk),
        .reset      (reset),
        .start_fntt (start_fntt),
        .start_intt (start_intt),
        .ct         (ct),
        .loop_bus   (loop_bus.counter)
    );

    // --------------------
    // address generators
    // --------------------
    ntt_twiddle_addr u_twiddle_addr (
        .clk      (clk),
        .reset    (reset),
        .loop_bus (loop_bus.user),
        .raddr_tw (raddr_tw)
    );

    ntt_read_addr u_read_addr (
        .clk      (clk),
        .reset    (reset),
        .loop_bus (loop_bus.user),
        .raddr    (raddr)
    );

    ntt_write_addr u_write_addr (
        .clk         (clk),
        .reset       (reset),
        .loop_bus    (loop_bus.user),
        .waddr0      (waddr0),
        .waddr1      (waddr1),
        .wen0        (wen0),
        .wen1        (wen1),
        .brsel0      (brsel0),
        .brsel1      (brsel1),
        .stage_count (stage_count)
    );

endmodule

// ==== verification/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== verification/tb_ntt_addr_gen.sv ====
module tb_ntt_addr_gen import ntt_addr_pkg::*; ();

    localparam int STEPS      = 896;
    localparam int MAX_XFORMS = 16;
    // edge offsets from the start edge for each output
    localparam int TW_OFS     = 2;
    localparam int RD_OFS     = 3;
    localparam int CT_OFS     = 4;
    localparam int EVEN_OFS   = 10;
    localparam int ODD_OFS    = 11;
    // edges watched in each run
    localparam int RUN_EDGES  = 911;
    // read side back at zero from here on
    localparam int DRAIN_EDGE = 899;

    logic       clk;
    logic       reset;
    logic       start_fntt;
    logic       start_intt;
    logic       ct;
    bank_addr_t raddr;
    tw_addr_t   raddr_tw;
    bank_addr_t waddr0;
    bank_addr_t waddr1;
    logic       wen0;
    logic       wen1;
    logic       brsel0;
    logic       brsel1;
    stage_t     stage_count;

    // three hex fields per transform
    logic [7:0] stim_mem [3*MAX_XFORMS];

    // reference values with one entry per butterfly step
    tw_addr_t   tw_ref    [STEPS];
    bank_addr_t rd_ref    [STEPS];
    bank_addr_t even_ref  [STEPS];
    bank_addr_t odd_ref   [STEPS];
    logic       lane_ref  [STEPS];
    stage_t     stage_ref [STEPS];

    int addr_errors;
    int tw_errors;
    int stage_errors;
    int bit_errors;
    int other_errors;
    int cycle_count;
    int cycle_limit;

    tb_clock u_tb_clock (
        .clk   (clk),
        .reset (reset)
    );

    ntt_addr_gen u_ntt_addr_gen (
        .clk         (clk),
        .reset       (reset),
        .start_fntt  (start_fntt),
        .start_intt  (start_intt),
        .ct          (ct),
        .raddr       (raddr),
        .raddr_tw    (raddr_tw),
        .waddr0      (waddr0),
        .waddr1      (waddr1),
        .wen0        (wen0),
        .wen1        (wen1),
        .brsel0      (brsel0),
        .brsel1      (brsel1),
        .stage_count (stage_count)
    );

    // --------------------
    // reference model
    // --------------------

    // step bit 0 lands at pos and bits 1..pos slide down
    function automatic half_addr_t permute_read(int v, int pos);
        int low;
        int high;
        low  = (v >> 1) % (1 << pos);
        high = (v / (2 << pos)) * (2 << pos);
        return half_addr_t'(high + ((v % 2) << pos) + low);
    endfunction

    // even partner of the butterfly for block width w
    function automatic half_addr_t even_write(int v, int w);
        return half_addr_t'((v / 2 + (v / (2 << w)) * (1 << w)) % 128);
    endfunction

    // twiddle counter change after step (s, l)
    function automatic int twiddle_step(xform_kind_t kind, int s, int l);
        if (l == 127) begin
            return 1;
        end
        if (kind == XFORM_FWD) begin
            if (s == 0) begin
                return 0;
            end
            return (l % (1 << (7 - s)) == (1 << (7 - s)) - 1) ? 1 : 0;
        end
        if (s == 6) begin
            return 0;
        end
        if (l % 2 == 0) begin
            return 1;
        end
        return (l % (1 << (s + 2)) == (1 << (s + 2)) - 1) ? 1 : -1;
    endfunction

    task automatic build_model(input xform_kind_t kind);
        int         tw;
        int         s;
        int         l;
        int         w;
        logic       rd_bank;
        half_addr_t rd_half;
        half_addr_t ev;
        half_addr_t od;
        tw = (kind == XFORM_FWD) ? 0 : 127;
        for (int n = 0; n < STEPS; n++) begin
            s = n / 128;
            l = n % 128;
            w = (kind == XFORM_FWD) ? 6 - s : s + 1;
            // inverse reads the upper half first
            rd_bank = (kind == XFORM_INV) ^ s[0];
            if (s == 6) begin
                rd_half = half_addr_t'(l);
                ev      = half_addr_t'(l);
                od      = half_addr_t'(l);
            end else begin
                rd_half = permute_read(l, w);
                ev      = even_write(l, w);
                od      = half_addr_t'((int'(ev) + (1 << w)) % 128);
            end
            tw_ref[n]    = tw_addr_t'(tw);
            rd_ref[n]    = {rd_bank, rd_half};
            even_ref[n]  = {~rd_bank, ev};
            odd_ref[n]   = {~rd_bank, od};
            lane_ref[n]  = l[0];
            stage_ref[n] = stage_t'(s);
            tw = (tw + twiddle_step(kind, s, l)) & 511;
        end
    endtask

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_bank_addr(input string name, input bank_addr_t got,
                                   input bank_addr_t exp);
        if (got !== exp) begin
            addr_errors++;
            $display("CHECK FAILED %s at cycle %0d: got 0x%h, expected 0x%h",
                     name, cycle_count, got, exp);
        end
    endtask

    task automatic check_tw_addr(input string name, input tw_addr_t got,
                                 input tw_addr_t exp);
        if (got !== exp) begin
            tw_errors++;
            $display("CHECK FAILED %s at cycle %0d: got 0x%h, expected 0x%h",
                     name, cycle_count, got, exp);
        end
    endtask

    task automatic check_stage(input string name, input stage_t got, input stage_t exp);
        if (got !== exp) begin
            stage_errors++;
            $display("CHECK FAILED %s at cycle %0d: got 0x%h, expected 0x%h",
                     name, cycle_count, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            bit_errors++;
            $display("CHECK FAILED %s at cycle %0d: got 0x%h, expected 0x%h",
                     name, cycle_count, got, exp);
        end
    endtask

    // twiddle and read ports read zero once drained
    task automatic check_read_side(input int e, input logic drained);
        int tw_n;
        int rd_n;
        tw_n = e - TW_OFS;
        rd_n = e - RD_OFS;
        if (tw_n >= 0 && tw_n < STEPS) begin
            check_tw_addr("raddr_tw", raddr_tw, tw_ref[tw_n]);
        end else if (drained) begin
            check_tw_addr("raddr_tw", raddr_tw, '0);
        end
        if (rd_n >= 0 && rd_n < STEPS) begin
            check_bank_addr("raddr", raddr, rd_ref[rd_n]);
        end else if (drained) begin
            check_bank_addr("raddr", raddr, '0);
        end
    endtask

    task automatic check_even_lane(input int n);
        if (n >= 0 && n < STEPS) begin
            check_bank_addr("waddr0", waddr0, even_ref[n]);
            check_bit("wen0", wen0, 1'b1);
            check_bit("brsel0", brsel0, lane_ref[n]);
        end else begin
            check_bank_addr("waddr0", waddr0, '0);
            check_bit("wen0", wen0, 1'b0);
            check_bit("brsel0", brsel0, 1'b0);
        end
    endtask

    // odd lane carries the stage number
    task automatic check_odd_lane(input int n);
        if (n >= 0 && n < STEPS) begin
            check_bank_addr("waddr1", waddr1, odd_ref[n]);
            check_bit("wen1", wen1, 1'b1);
            check_bit("brsel1", brsel1, lane_ref[n]);
            check_stage("stage_count", stage_count, stage_ref[n]);
        end else begin
            check_bank_addr("waddr1", waddr1, '0);
            check_bit("wen1", wen1, 1'b0);
            check_bit("brsel1", brsel1, 1'b0);
            check_stage("stage_count", stage_count, '0);
        end
    endtask

    task automatic check_idle(input logic exp_ct);
        check_read_side(-1, 1'b1);
        check_even_lane(-1);
        check_odd_lane(-1);
        check_bit("ct", ct, exp_ct);
    endtask

    // --------------------
    // timeout
    // --------------------
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    // --------------------
    // stimulus
    // --------------------
    initial begin
        int          n_xforms;
        int          kind_code;
        int          gap;
        int          busy_edge;
        int          total;
        logic        exp_ct;
        logic        prev_ct;
        logic        run_ct;
        xform_kind_t kind;
        start_fntt   = 1'b0;
        start_intt   = 1'b0;
        addr_errors  = 0;
        tw_errors    = 0;
        stage_errors = 0;
        bit_errors   = 0;
        other_errors = 0;
        cycle_count  = 0;
        cycle_limit  = 0;
        void'($urandom(75));

        // unused entries keep the ff marker
        for (int i = 0; i < 3 * MAX_XFORMS; i++) begin
            stim_mem[i] = 8'hff;
        end
        $readmemh("verification/ntt_input.txt", stim_mem);
        n_xforms = 0;
        while (n_xforms < MAX_XFORMS && stim_mem[3*n_xforms] != 8'hff) begin
            n_xforms++;
        end
        if (n_xforms == 0) begin
            other_errors++;
            $display("input file holds no transforms");
        end
        cycle_limit = n_xforms * 930 + 50;

        wait (reset === 1'b1);
        wait (reset === 1'b0);
        prev_ct = 1'b0;
        repeat (4) begin
            @(posedge clk);
            @(negedge clk);
            check_idle(prev_ct);
        end

        for (int x = 0; x < n_xforms; x++) begin
            kind_code = int'(stim_mem[3*x]);
            gap       = int'(stim_mem[3*x+1]) + int'($urandom % 4);
            exp_ct    = stim_mem[3*x+2][0];
            if (kind_code > 2) begin
                other_errors++;
                $display("input line %0d has an unknown transform kind %0d", x, kind_code);
                kind_code = 0;
            end
            // both strobes together run forward
            kind   = (kind_code == 1) ? XFORM_INV : XFORM_FWD;
            run_ct = (kind == XFORM_FWD);
            build_model(kind);
            busy_edge = 100 + int'($urandom % 700);

            // one-cycle strobe sampled at edge 0
            start_fntt = (kind_code != 1);
            start_intt = (kind_code != 0);
            @(posedge clk);
            @(negedge clk);
            start_fntt = 1'b0;
            start_intt = 1'b0;

            for (int e = 1; e <= RUN_EDGES; e++) begin
                @(posedge clk);
                @(negedge clk);
                check_read_side(e, e >= DRAIN_EDGE);
                check_even_lane(e - EVEN_OFS);
                check_odd_lane(e - ODD_OFS);
                check_bit("ct", ct, (e < CT_OFS) ? prev_ct : run_ct);
                // opposite strobe mid-run is ignored
                if (e == busy_edge - 1) begin
                    if (kind == XFORM_FWD) begin
                        start_intt = 1'b1;
                    end else begin
                        start_fntt = 1'b1;
                    end
                end else begin
                    start_fntt = 1'b0;
                    start_intt = 1'b0;
                end
            end
            check_bit("ct", ct, exp_ct);
            prev_ct = run_ct;

            repeat (gap) begin
                @(posedge clk);
                @(negedge clk);
                check_idle(prev_ct);
            end
        end

        total = addr_errors + tw_errors + stage_errors + bit_errors + other_errors;
        $display("errors: bank_addr %0d, tw_addr %0d, stage %0d, bit %0d, other %0d",
                 addr_errors, tw_errors, stage_errors, bit_errors, other_errors);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== verification/ntt_input.txt ====
// kind (0 forward, 1 inverse, 2 both strobes), idle gap in cycles, expected ct
// one transform per line, all fields hex
0 3 1
1 5 0
1 2 0
2 a 1
0 1 1
1 7 0
0 4 1
2 6 1

// ==== tb.f ====
verilog/ntt_addr_pkg.sv
verilog/ntt_loop_if.sv
verilog/delay_line.sv
verilog/ntt_loop_counter.sv
verilog/ntt_twiddle_addr.sv
verilog/ntt_read_addr.sv
verilog/ntt_write_addr.sv
verilog/ntt_addr_gen.sv
verification/tb_clock.sv
verification/tb_ntt_addr_gen.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the testbench with verilator, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_ntt_addr_gen -f tb.f -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
